//--- logic/cart_cfg.svh
/*
 * Cartridge loader configuration
 * Bus widths, cartridge header addresses and the size of the game quirk table
 */

`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// Host download port
`define CART_ADDR_W 25
`define CART_DATA_W 16

// Region letters, both bytes of the first word and the low byte of the second
`define HDR_REGION_ADDR_A 25'h1F0
`define HDR_REGION_ADDR_B 25'h1F2

// First word after the header
`define HDR_END_ADDR 25'h200

// Product ID words and the address at which the ID is complete
`define HDR_ID_ADDR_0 25'h182
`define HDR_ID_ADDR_1 25'h184
`define HDR_ID_ADDR_2 25'h186
`define HDR_ID_ADDR_3 25'h188
`define HDR_ID_ADDR_4 25'h18A
`define HDR_ID_DONE_ADDR 25'h18C

// Entries in the per-game quirk table
`define QUIRK_TABLE_SIZE 24

`endif

//--- logic/cart_pkg.sv
/*
 * Cartridge loader types
 * Download port bundle, region codes, header region flags and quirk flags
 */

`default_nettype none

`include "cart_cfg.svh"

package cart_pkg;

	// Host download port as seen by every stage
	typedef struct packed {
		logic                    download;
		logic                    wr;
		logic [`CART_ADDR_W-1:0] addr;
		logic [`CART_DATA_W-1:0] data;
		logic [7:0]              index;
	} ioctl_bus_t;

	// Console region, same coding as the system status bits
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// Region letters found in the header
	typedef struct packed {
		logic hdr_j;
		logic hdr_u;
		logic hdr_e;
	} hdr_flags_t;

	// Compatibility quirks, sram in the top bit down to schan in bit 0
	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirk_t;

endpackage

`default_nettype wire

//--- logic/header_decode.sv
/*
 * Cartridge header decode
 * Snoops download writes for the region letters and the product ID,
 * and flags the end of the header
 */

`timescale 1ns/10ps
`default_nettype none

`include "cart_cfg.svh"

module header_decode (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  cart_pkg::ioctl_bus_t   ioctl,
	output cart_pkg::hdr_flags_t   hdr_flags,
	output logic                   hdr_ready,
	output logic [63:0]            cart_id
);

	logic                 dl_prev;
	logic                 dl_start;
	logic                 dl_end;
	logic                 wr_hit;
	logic                 region_wr;
	cart_pkg::hdr_flags_t region_bits;

	// One region letter, anything printable from 0 to Z that is not J or U means EU
	function automatic cart_pkg::hdr_flags_t decode_letter(input logic [7:0] ch);
		cart_pkg::hdr_flags_t f;
		f = '0;
		if (ch == "J")
			f.hdr_j = 1'b1;
		else if (ch == "U")
			f.hdr_u = 1'b1;
		else if (ch >= "0" && ch <= "Z")
			f.hdr_e = 1'b1;
		return f;
	endfunction

	assign dl_start = ioctl.download & ~dl_prev;
	assign dl_end   = dl_prev & ~ioctl.download;
	assign wr_hit   = ioctl.download & ioctl.wr;

	assign region_wr = wr_hit &&
		(ioctl.addr == `HDR_REGION_ADDR_A || ioctl.addr == `HDR_REGION_ADDR_B);

	always_comb begin
		region_bits = decode_letter(ioctl.data[7:0]);
		// High byte only counts in the first word
		if (ioctl.addr == `HDR_REGION_ADDR_A)
			region_bits = cart_pkg::hdr_flags_t'(region_bits | decode_letter(ioctl.data[15:8]));
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dl_prev   <= 1'b0;
			hdr_flags <= '0;
			hdr_ready <= 1'b0;
		end else begin
			dl_prev <= ioctl.download;

			if (dl_start)
				hdr_flags <= '0;
			else if (region_wr)
				hdr_flags <= cart_pkg::hdr_flags_t'(hdr_flags | region_bits);

			if (dl_end)
				hdr_ready <= 1'b0;
			else if (wr_hit && ioctl.addr == `HDR_END_ADDR)
				hdr_ready <= 1'b1;
		end
	end

	// Product ID, bytes arrive swapped within each word
	always_ff @(posedge clk_sys) begin
		if (wr_hit) begin
			case (ioctl.addr)
				`HDR_ID_ADDR_0: cart_id[63:56] <= ioctl.data[15:8];
				`HDR_ID_ADDR_1: cart_id[55:40] <= {ioctl.data[7:0], ioctl.data[15:8]};
				`HDR_ID_ADDR_2: cart_id[39:24] <= {ioctl.data[7:0], ioctl.data[15:8]};
				`HDR_ID_ADDR_3: cart_id[23:8]  <= {ioctl.data[7:0], ioctl.data[15:8]};
				`HDR_ID_ADDR_4: cart_id[7:0]   <= ioctl.data[7:0];
				default: ;
			endcase
		end
	end

	// Region flags only move during a download
	flags_quiet_when_idle: assert property (@(posedge clk_sys) disable iff (rst)
		!ioctl.download |=> $stable(hdr_flags));

endmodule

`default_nettype wire

//--- logic/quirk_match.sv
/*
 * Game quirk match
 * Compares the header product ID with the known game table when the ID is complete
 */

`timescale 1ns/10ps
`default_nettype none

`include "cart_cfg.svh"

module quirk_match (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  cart_pkg::ioctl_bus_t ioctl,
	input  logic [63:0]          cart_id,
	output cart_pkg::quirk_t     quirks
);

	// Bit positions in quirk_t
	localparam logic [2:0] Q_SRAM   = 3'd7;
	localparam logic [2:0] Q_EEPROM = 3'd6;
	localparam logic [2:0] Q_NORAM  = 3'd5;
	localparam logic [2:0] Q_FIFO   = 3'd4;
	localparam logic [2:0] Q_PIER   = 3'd3;
	localparam logic [2:0] Q_SVP    = 3'd2;
	localparam logic [2:0] Q_FMBUSY = 3'd1;
	localparam logic [2:0] Q_SCHAN  = 3'd0;

	//////////////////////////////////////////////////////////////////////////
	// Known games, first entry wins
	//////////////////////////////////////////////////////////////////////////

	localparam logic [63:0] GAME_ID [`QUIRK_TABLE_SIZE] = '{
		"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ",
		"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
		"00004076", "T-12046 ", "T-12053 ", "G-4524  ",
		"T-113016", "T-89016 ", "T-574023", "T-574013",
		"MK-1229 ", "G-7001  ", "T-35036 ", "T-25073 ", "MK-1137-",
		"T-68???-"
	};

	localparam logic [2:0] GAME_FLAG [`QUIRK_TABLE_SIZE] = '{
		Q_SRAM, Q_SRAM, Q_SRAM, Q_SRAM, Q_SRAM,
		Q_EEPROM, Q_EEPROM, Q_EEPROM, Q_EEPROM, Q_EEPROM,
		Q_EEPROM, Q_EEPROM, Q_EEPROM, Q_EEPROM,
		Q_NORAM, Q_FIFO, Q_PIER, Q_PIER,
		Q_SVP, Q_SVP, Q_FMBUSY, Q_FMBUSY, Q_FMBUSY,
		Q_SCHAN
	};

	logic       dl_prev;
	logic       id_done;
	logic [7:0] match_vec;

	assign id_done = ioctl.download & ioctl.wr & (ioctl.addr == `HDR_ID_DONE_ADDR);

	// Scan from the end so the lowest matching entry is left standing
	always_comb begin
		match_vec = '0;
		for (int i = `QUIRK_TABLE_SIZE - 1; i >= 0; i--) begin
			if (cart_id == GAME_ID[i]) begin
				match_vec = '0;
				match_vec[GAME_FLAG[i]] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dl_prev <= 1'b0;
			quirks  <= '0;
		end else begin
			dl_prev <= ioctl.download;
			if (ioctl.download & ~dl_prev)
				quirks <= '0;
			else if (id_done)
				quirks <= cart_pkg::quirk_t'(quirks | match_vec);
		end
	end

	// One game, one quirk
	single_quirk: assert property (@(posedge clk_sys) disable iff (rst)
		$onehot0(quirks));

endmodule

`default_nettype wire

//--- logic/region_select.sv
/*
 * Console region select
 * Picks the region from the header letters or the file index once the header is in
 */

`timescale 1ns/10ps
`default_nettype none

module region_select (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  cart_pkg::ioctl_bus_t ioctl,
	input  cart_pkg::hdr_flags_t hdr_flags,
	input  logic                 hdr_ready,
	input  logic                 auto_region_off,
	input  logic                 region_from_header,
	input  logic [1:0]           region_priority,
	output cart_pkg::region_t    region_req,
	output logic                 region_set
);

	logic ready_prev;
	logic ready_rise;
	logic ready_fall;

	// First letter present in priority order, else the order's own default
	function automatic cart_pkg::region_t pick_region(
		input cart_pkg::hdr_flags_t f,
		input logic [1:0]           prio
	);
		cart_pkg::region_t r;
		case (prio)
			2'd0: r = f.hdr_u ? cart_pkg::REGION_US :
				f.hdr_e ? cart_pkg::REGION_EU :
				f.hdr_j ? cart_pkg::REGION_JP : cart_pkg::REGION_US;
			2'd1: r = f.hdr_e ? cart_pkg::REGION_EU :
				f.hdr_u ? cart_pkg::REGION_US :
				f.hdr_j ? cart_pkg::REGION_JP : cart_pkg::REGION_EU;
			2'd2: r = f.hdr_u ? cart_pkg::REGION_US :
				f.hdr_j ? cart_pkg::REGION_JP :
				f.hdr_e ? cart_pkg::REGION_EU : cart_pkg::REGION_US;
			default: r = f.hdr_j ? cart_pkg::REGION_JP :
				f.hdr_u ? cart_pkg::REGION_US :
				f.hdr_e ? cart_pkg::REGION_EU : cart_pkg::REGION_JP;
		endcase
		return r;
	endfunction

	assign ready_rise = hdr_ready & ~ready_prev;
	assign ready_fall = ready_prev & ~hdr_ready;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ready_prev <= 1'b0;
			region_set <= 1'b0;
		end else begin
			ready_prev <= hdr_ready;
			if (ready_rise && !auto_region_off)
				region_set <= region_from_header ? 1'b1 : |ioctl.index;
			if (ready_fall)
				region_set <= 1'b0;
		end
	end

	// Requested region, held until the next header
	always_ff @(posedge clk_sys) begin
		if (ready_rise && !auto_region_off) begin
			if (region_from_header)
				region_req <= pick_region(hdr_flags, region_priority);
			else
				region_req <= cart_pkg::region_t'(ioctl.index[7:6]);
		end
	end

	// Header mode only ever yields JP, US or EU
	header_region_valid: assert property (@(posedge clk_sys) disable iff (rst)
		(ready_rise && !auto_region_off && region_from_header) |=> region_req != 2'd3);

endmodule

`default_nettype wire

//--- logic/rom_write_ctrl.sv
/*
 * ROM write control
 * Forwards download words to memory over a toggle request/acknowledge pair,
 * holds the host in wait while a write is open and latches the ROM size
 */

`timescale 1ns/10ps
`default_nettype none

`include "cart_cfg.svh"

module rom_write_ctrl (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  cart_pkg::ioctl_bus_t    ioctl,
	input  logic                    rom_wrack,
	output logic                    ioctl_wait,
	output logic                    rom_wr,
	output logic [`CART_ADDR_W-2:0] rom_addr,
	output logic [`CART_DATA_W-1:0] rom_din,
	output logic [`CART_ADDR_W-1:0] rom_sz
);

	logic dl_prev;
	logic dl_start;
	logic dl_end;
	logic wr_hit;

	assign dl_start = ioctl.download & ~dl_prev;
	assign dl_end   = dl_prev & ~ioctl.download;
	assign wr_hit   = ioctl.download & ioctl.wr;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dl_prev    <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_wr     <= 1'b0;
			rom_sz     <= '0;
		end else begin
			dl_prev <= ioctl.download;

			// Last address of the image is its size
			if (dl_end) begin
				rom_sz     <= ioctl.addr;
				ioctl_wait <= 1'b0;
			end

			if (dl_start) begin
				rom_wr <= 1'b0;
			end else if (ioctl.download) begin
				if (ioctl.wr) begin
					ioctl_wait <= 1'b1;
					rom_wr     <= ~rom_wr;
				end else if (ioctl_wait && rom_wr == rom_wrack) begin
					ioctl_wait <= 1'b0;
				end
			end
		end
	end

	// Word address and byte-swapped data for the memory
	always_ff @(posedge clk_sys) begin
		if (wr_hit && !dl_start) begin
			rom_addr <= ioctl.addr[`CART_ADDR_W-1:1];
			rom_din  <= {ioctl.data[7:0], ioctl.data[15:8]};
		end
	end

	// A request toggle needs a host write or a fresh download behind it
	wr_toggle_source: assert property (@(posedge clk_sys) disable iff (rst)
		$changed(rom_wr) |-> $past(wr_hit || dl_start));

endmodule

`default_nettype wire

//--- logic/cart_loader.sv
/*
 * Cartridge loader top level
 * Write forwarding, header decode, region select and game quirk match
 */

`timescale 1ns/10ps
`default_nettype none

`include "cart_cfg.svh"

module cart_loader (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  cart_pkg::ioctl_bus_t    ioctl,
	input  logic                    auto_region_off,
	input  logic                    region_from_header,
	input  logic [1:0]              region_priority,
	output logic                    ioctl_wait,
	output logic                    rom_wr,
	output logic [`CART_ADDR_W-2:0] rom_addr,
	output logic [`CART_DATA_W-1:0] rom_din,
	input  logic                    rom_wrack,
	output logic [`CART_ADDR_W-1:0] rom_sz,
	output cart_pkg::region_t       region_req,
	output logic                    region_set,
	output cart_pkg::quirk_t        quirks
);

	cart_pkg::hdr_flags_t hdr_flags;
	logic                 hdr_ready;
	logic [63:0]          cart_id;

	////////////////////////////////////////////////////////////////////////////
	// Header snoop
	////////////////////////////////////////////////////////////////////////////

	header_decode header_decode_inst (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ioctl     (ioctl),
		.hdr_flags (hdr_flags),
		.hdr_ready (hdr_ready),
		.cart_id   (cart_id)
	);

	quirk_match quirk_match_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ioctl   (ioctl),
		.cart_id (cart_id),
		.quirks  (quirks)
	);

	region_select region_select_inst (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.ioctl              (ioctl),
		.hdr_flags          (hdr_flags),
		.hdr_ready          (hdr_ready),
		.auto_region_off    (auto_region_off),
		.region_from_header (region_from_header),
		.region_priority    (region_priority),
		.region_req         (region_req),
		.region_set         (region_set)
	);

	////////////////////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////////////////////

	rom_write_ctrl rom_write_ctrl_inst (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.ioctl      (ioctl),
		.rom_wrack  (rom_wrack),
		.ioctl_wait (ioctl_wait),
		.rom_wr     (rom_wr),
		.rom_addr   (rom_addr),
		.rom_din    (rom_din),
		.rom_sz     (rom_sz)
	);

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
/*
 * Testbench clock and reset
 * 100 ns system clock, reset held high for the first 8 cycles
 */

`timescale 1ns/10ps
`default_nettype none

module clock_gen (
	output logic clk_sys,
	output logic rst
);

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// Release on a falling edge, clear of the sampling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- verification/cart_loader_tb.sv
/*
 * Cartridge loader testbench
 * Loads header images through the download port against a memory model
 * with random acknowledge delay and checks every response by assertion
 */

`timescale 1ns/10ps
`default_nettype none

`include "cart_cfg.svh"

module cart_loader_tb;

	localparam int WAIT_LIMIT = 40;

	logic                    clk_sys;
	logic                    rst;
	cart_pkg::ioctl_bus_t    ioctl;
	logic                    auto_region_off;
	logic                    region_from_header;
	logic [1:0]              region_priority;
	logic                    ioctl_wait;
	logic                    rom_wr;
	logic [`CART_ADDR_W-2:0] rom_addr;
	logic [`CART_DATA_W-1:0] rom_din;
	logic                    rom_wrack = 1'b0;
	logic [`CART_ADDR_W-1:0] rom_sz;
	cart_pkg::region_t       region_req;
	logic                    region_set;
	cart_pkg::quirk_t        quirks;

	// Memory model state
	integer      seed = 69206;
	int unsigned ack_left = 0;
	logic        ack_busy = 1'b0;

	// Expected values and run statistics
	string                   test_name = "reset";
	int                      errors = 0;
	int                      downloads = 0;
	int                      words = 0;
	logic [1:0]              exp_req = 2'd0;
	logic                    exp_set = 1'b0;
	cart_pkg::quirk_t        exp_quirks = '0;
	logic [`CART_DATA_W-1:0] exp_din = '0;
	logic [`CART_ADDR_W-2:0] exp_addr = '0;
	logic [`CART_ADDR_W-1:0] last_wr_addr = '0;

	// Download events seen from the host side
	logic dl_prev = 1'b0;
	logic dl_fall_d = 1'b0;
	logic hdr_end_d = 1'b0;
	logic wr_hit;
	logic dl_rise;
	logic dl_fall;

	clock_gen clock_gen_inst (
		.clk_sys (clk_sys),
		.rst     (rst)
	);

	cart_loader cart_loader_inst (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.ioctl              (ioctl),
		.auto_region_off    (auto_region_off),
		.region_from_header (region_from_header),
		.region_priority    (region_priority),
		.ioctl_wait         (ioctl_wait),
		.rom_wr             (rom_wr),
		.rom_addr           (rom_addr),
		.rom_din            (rom_din),
		.rom_wrack          (rom_wrack),
		.rom_sz             (rom_sz),
		.region_req         (region_req),
		.region_set         (region_set),
		.quirks             (quirks)
	);

	// Memory answers each request toggle after 0 to 5 cycles
	always @(negedge clk_sys) begin
		if (rst) begin
			rom_wrack = 1'b0;
			ack_busy  = 1'b0;
		end else if (ack_busy) begin
			ack_left = ack_left - 1;
			if (ack_left == 0) begin
				rom_wrack = rom_wr;
				ack_busy  = 1'b0;
			end
		end else if (rom_wr != rom_wrack) begin
			ack_left = {$random(seed)} % 6;
			if (ack_left == 0)
				rom_wrack = rom_wr;
			else
				ack_busy = 1'b1;
		end
	end

	assign wr_hit  = ioctl.download & ioctl.wr;
	assign dl_rise = ioctl.download & ~dl_prev;
	assign dl_fall = dl_prev & ~ioctl.download;

	always @(posedge clk_sys) begin
		dl_prev   <= ioctl.download;
		dl_fall_d <= dl_fall;
		hdr_end_d <= wr_hit && ioctl.addr == `HDR_END_ADDR;
		if (wr_hit)
			last_wr_addr <= ioctl.addr;
	end

	////////////////////////////////////////////////////////////////////////////
	// Error counting
	////////////////////////////////////////////////////////////////////////////

	task automatic mismatch(input string check, input logic [63:0] expected,
		input logic [63:0] actual);
		errors++;
		$display("ERROR %s %s: expected %0h, actual %0h", test_name, check, expected, actual);
	endtask

	task automatic failure(input string what);
		errors++;
		$display("Test %s: %s", test_name, what);
	endtask

	task automatic timeout_abort(input string what);
		$display("Test %s: timed out waiting for %s", test_name, what);
		$display("CHECKS FAILED");
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	write_data_ok: assert property (@(posedge clk_sys) disable iff (rst)
		wr_hit |=> rom_din == exp_din)
		else mismatch("rom_din", 64'(exp_din), 64'($sampled(rom_din)));

	write_addr_ok: assert property (@(posedge clk_sys) disable iff (rst)
		wr_hit |=> rom_addr == exp_addr)
		else mismatch("rom_addr", 64'(exp_addr), 64'($sampled(rom_addr)));

	request_toggles: assert property (@(posedge clk_sys) disable iff (rst)
		wr_hit |=> rom_wr != $past(rom_wr))
		else failure("rom_wr did not toggle after a write");

	wait_rises: assert property (@(posedge clk_sys) disable iff (rst)
		wr_hit |=> ioctl_wait)
		else failure("ioctl_wait did not rise after a write");

	wait_holds: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wait && rom_wr != rom_wrack |=> ioctl_wait)
		else failure("ioctl_wait fell before the acknowledge");

	wait_falls: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wait && rom_wr == rom_wrack && !wr_hit |=> !ioctl_wait)
		else failure("ioctl_wait stayed high after the acknowledge");

	size_latched: assert property (@(posedge clk_sys) disable iff (rst)
		dl_fall |=> rom_sz == last_wr_addr)
		else mismatch("rom_sz", 64'(last_wr_addr), 64'($sampled(rom_sz)));

	region_set_ok: assert property (@(posedge clk_sys) disable iff (rst)
		hdr_end_d |=> region_set == exp_set)
		else mismatch("region_set", 64'(exp_set), 64'($sampled(region_set)));

	region_req_ok: assert property (@(posedge clk_sys) disable iff (rst)
		hdr_end_d && !auto_region_off |=> region_req == exp_req)
		else mismatch("region_req", 64'(exp_req), 64'($sampled(region_req)));

	region_set_clears: assert property (@(posedge clk_sys) disable iff (rst)
		dl_fall_d |=> !region_set)
		else failure("region_set still high after the download ended");

	quirks_ok: assert property (@(posedge clk_sys) disable iff (rst)
		wr_hit && ioctl.addr == `HDR_ID_DONE_ADDR |=> quirks == exp_quirks)
		else mismatch("quirks", 64'(exp_quirks), 64'($sampled(quirks)));

	quirks_clear: assert property (@(posedge clk_sys) disable iff (rst)
		dl_rise |=> quirks == '0)
		else failure("quirk flags not cleared at download start");

	////////////////////////////////////////////////////////////////////////////
	// Image contents and expected results
	////////////////////////////////////////////////////////////////////////////

	// Header text on top of a fill that depends on every address bit
	function automatic logic [7:0] image_byte(input logic [`CART_ADDR_W-1:0] a,
		input logic [23:0] letters, input logic [63:0] id);
		int         k;
		logic [7:0] b;
		b = a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]} ^ 8'hC3;
		if (a > `HDR_ID_ADDR_0 && a <= `HDR_ID_ADDR_4) begin
			k = int'(a - `HDR_ID_ADDR_0) - 1;
			b = id[8*(7-k) +: 8];
		end else if (a >= `HDR_REGION_ADDR_A && a <= `HDR_REGION_ADDR_B) begin
			k = int'(a - `HDR_REGION_ADDR_A);
			b = letters[8*(2-k) +: 8];
		end
		return b;
	endfunction

	// Little-endian download word with the even byte in the low half
	function automatic logic [15:0] image_word(input logic [`CART_ADDR_W-1:0] a,
		input logic [23:0] letters, input logic [63:0] id);
		return {image_byte(a + 25'd1, letters, id), image_byte(a, letters, id)};
	endfunction

	function automatic logic [1:0] expected_region(input logic [23:0] letters,
		input logic [1:0] prio);
		logic [2:0] seen;
		logic [5:0] order;
		logic [7:0] ch;
		logic [1:0] pick;
		seen = '0;
		for (int i = 0; i < 3; i++) begin
			ch = letters[8*i +: 8];
			if (ch == "J")
				seen[cart_pkg::REGION_JP] = 1'b1;
			else if (ch == "U")
				seen[cart_pkg::REGION_US] = 1'b1;
			else if (ch >= "0" && ch <= "Z")
				seen[cart_pkg::REGION_EU] = 1'b1;
		end
		// First choice sits in the top bits and doubles as the default
		case (prio)
			2'd0: order = {cart_pkg::REGION_US, cart_pkg::REGION_EU, cart_pkg::REGION_JP};
			2'd1: order = {cart_pkg::REGION_EU, cart_pkg::REGION_US, cart_pkg::REGION_JP};
			2'd2: order = {cart_pkg::REGION_US, cart_pkg::REGION_JP, cart_pkg::REGION_EU};
			default: order = {cart_pkg::REGION_JP, cart_pkg::REGION_US, cart_pkg::REGION_EU};
		endcase
		pick = order[5:4];
		for (int k = 0; k < 3; k++)
			if (seen[order[2*k +: 2]])
				pick = order[2*k +: 2];
		return pick;
	endfunction

	function automatic cart_pkg::quirk_t expected_quirks(input logic [63:0] id);
		cart_pkg::quirk_t q;
		q = '0;
		if (id == "MK-1229 ")
			q.svp = 1'b1;
		else if (id == "T-081276")
			q.sram = 1'b1;
		return q;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// Sample on the rising edge and hand back on the falling edge
	task automatic wait_idle(input string what);
		int n;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
			if (n > WAIT_LIMIT)
				timeout_abort(what);
		end while (ioctl_wait || rom_wr != rom_wrack);
		@(negedge clk_sys);
	endtask

	task automatic load_image(input string name, input logic [23:0] letters,
		input logic [63:0] id, input logic [7:0] index,
		input logic [`CART_ADDR_W-1:0] last);
		logic [`CART_ADDR_W-1:0] a;
		logic [`CART_ADDR_W-2:0] w;
		test_name  = name;
		exp_quirks = expected_quirks(id);
		exp_set    = !auto_region_off && (region_from_header || (|index));
		exp_req    = region_from_header ? expected_region(letters, region_priority) :
			index[7:6];
		ioctl.index    = index;
		ioctl.download = 1'b1;
		@(negedge clk_sys);
		wait_idle("the memory to settle at download start");
		a = '0;
		w = '0;
		while (a <= last) begin
			ioctl.addr = a;
			ioctl.data = image_word(a, letters, id);
			ioctl.wr   = 1'b1;
			// Memory holds the even byte in the high half at one address per word
			exp_din  = {image_byte(a, letters, id), image_byte(a + 25'd1, letters, id)};
			exp_addr = w;
			@(negedge clk_sys);
			ioctl.wr = 1'b0;
			words++;
			wait_idle("ioctl_wait to fall");
			a = a + 25'd2;
			w++;
		end
		ioctl.download = 1'b0;
		// Region strobe drops two cycles after the end
		repeat (4) @(negedge clk_sys);
		downloads++;
	endtask

	initial begin
		int n;
		ioctl              = '0;
		auto_region_off    = 1'b0;
		region_from_header = 1'b1;
		region_priority    = 2'd0;

		n = 0;
		while (rst !== 1'b0) begin
			@(posedge clk_sys);
			n++;
			if (n > 20)
				timeout_abort("reset release");
		end
		@(negedge clk_sys);

		// Header letters under the priority orders
		load_image("hdr_jue_p0", "JUE", "MK-1229 ", 8'h00, 25'h200);
		region_priority = 2'd1;
		load_image("hdr_jue_p1", "JUE", "T-081276", 8'h00, 25'h21E);
		region_priority = 2'd3;
		load_image("hdr_jue_p3", "JUE", "XX-00000", 8'h00, 25'h20A);
		region_priority = 2'd2;
		load_image("hdr_j_p2", "J  ", "XX-00000", 8'h00, 25'h200);
		region_priority = 2'd0;
		load_image("hdr_j_p0", "J  ", "T-081276", 8'h00, 25'h200);
		region_priority = 2'd3;
		load_image("hdr_e_p3", "E  ", "MK-1229 ", 8'h00, 25'h200);
		for (int p = 0; p < 4; p++) begin
			region_priority = 2'(p);
			load_image($sformatf("hdr_none_p%0d", p), "   ", "XX-00000", 8'h00, 25'h202);
		end

		// File index picks the region
		region_from_header = 1'b0;
		load_image("idx_eu", "JUE", "MK-1229 ", 8'h80, 25'h200);
		load_image("idx_us", "JUE", "XX-00000", 8'h41, 25'h200);
		load_image("idx_zero", "JUE", "XX-00000", 8'h00, 25'h200);
		auto_region_off = 1'b1;
		load_image("idx_auto_off", "JUE", "T-081276", 8'hC1, 25'h200);

		$display("Downloads %0d, words %0d, errors %0d", downloads, words, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
logic/cart_pkg.sv
logic/header_decode.sv
logic/quirk_match.sv
logic/region_select.sv
logic/rom_write_ctrl.sv
logic/cart_loader.sv
verification/clock_gen.sv
verification/cart_loader_tb.sv

//--- Makefile
# Verilator build and run for the cartridge loader

VERILATOR  ?= verilator
TOP        ?= cart_loader_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --assert
PASS_TEXT  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Status comes from the pass line in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
